// File: bench/serial_line_model.sv
module serial_line_model #(
	parameter int CLOCKS_PER_BAUD = 16
) (
	input  logic i_clk,
	input  logic i_line,
	output logic o_line
);
	timeunit 1ns;
	timeprecision 100ps;

	import uart_pkg::*;

	// the line rests at the marking level until the first frame
	logic line_q = 1'b1;

	assign o_line = line_q;

	//////////////////////////////////////////////////
	// sender
	//////////////////////////////////////////////////

	// start bit, eight data bits lsb first, stop bit, then the idle gap
	// every level is set on a falling edge and held for a whole bit
	task automatic send_frame(input byte_t data, input int gap_bits);
		logic [9:0] frame;
		int         i;
		frame = {1'b1, data, 1'b0};
		for (i = 0; i < 10; i++)
		begin
			@(negedge i_clk);
			line_q = frame[i];
			repeat (CLOCKS_PER_BAUD - 1) @(negedge i_clk);
		end
		repeat (gap_bits * CLOCKS_PER_BAUD) @(negedge i_clk);
	endtask

	//////////////////////////////////////////////////
	// receiver
	//////////////////////////////////////////////////

	// waits up to limit cycles for a falling edge, then samples each bit
	// half a bit into it, counting cycles from the edge on falling clocks
	// first_change is the cycle count at which the line first leaves low
	task automatic recv_frame(
		input  int    limit,
		output byte_t data,
		output logic  start_lvl,
		output logic  stop_lvl,
		output int    first_change,
		output logic  timed_out
	);
		logic prev;
		int   waited;
		int   c;
		int   b;
		data         = '0;
		start_lvl    = 1'b1;
		stop_lvl     = 1'b0;
		first_change = 0;
		waited       = 0;
		prev         = i_line;
		@(negedge i_clk);
		while (!(prev && !i_line) && (waited < limit))
		begin
			prev = i_line;
			@(negedge i_clk);
			waited++;
		end
		timed_out = !(prev && !i_line);
		if (timed_out)
			return;
		// stops at the centre of the stop bit, so the next edge is not missed
		for (c = 1; c <= 9 * CLOCKS_PER_BAUD + CLOCKS_PER_BAUD / 2; c++)
		begin
			@(negedge i_clk);
			if ((first_change == 0) && i_line)
				first_change = c;
			if ((c % CLOCKS_PER_BAUD) == CLOCKS_PER_BAUD / 2)
			begin
				b = c / CLOCKS_PER_BAUD;
				if (b == 0)
					start_lvl = i_line;
				else if (b == 9)
					stop_lvl = i_line;
				else
					data[b-1] = i_line;
			end
		end
	endtask

endmodule

// File: bench/uart_echo_tb.sv
module uart_echo_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import uart_pkg::*;

	localparam int CPB        = 16;
	localparam int NUM_FRAMES = 44;
	// an echo starts about ten bits after its input, so forty is ample
	localparam int RECV_LIMIT = 40 * CPB;

	logic  clk = 1'b0;
	logic  arst_n;
	logic  uart_rx;
	logic  uart_tx;
	int    seed;
	int    cyc;
	int    n;
	byte_t tx_bytes [NUM_FRAMES];
	int    tx_gaps [NUM_FRAMES];
	// bytes sent and not yet seen on the output, oldest first
	byte_t exp_q [$];

	always #4 clk = ~clk;

	uart_echo_top #(
		.CLOCKS_PER_BAUD(baud_cnt_t'(CPB))
	) dut0 (
		.i_clk     (clk),
		.i_arst_n  (arst_n),
		.i_uart_rx (uart_rx),
		.o_uart_tx (uart_tx)
	);

	serial_line_model #(
		.CLOCKS_PER_BAUD(CPB)
	) line0 (
		.i_clk  (clk),
		.i_line (uart_tx),
		.o_line (uart_rx)
	);

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at t=%0t while waiting for the %s", $time, what);
		abort_run();
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s got 8'h%02h expected 8'h%02h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_line(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s got %b expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_cycles(input baud_cnt_t got, input baud_cnt_t exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s lasted %0d cycles, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// traffic
	//////////////////////////////////////////////////

	task automatic send_all();
		int i;
		for (i = 0; i < NUM_FRAMES; i++)
		begin
			exp_q.push_back(tx_bytes[i]);
			line0.send_frame(tx_bytes[i], tx_gaps[i]);
		end
	endtask

	// each output frame must match the oldest byte still outstanding
	task automatic recv_all();
		byte_t got;
		byte_t exp;
		logic  start_lvl;
		logic  stop_lvl;
		int    first_change;
		logic  timed_out;
		int    i;
		for (i = 0; i < NUM_FRAMES; i++)
		begin
			line0.recv_frame(RECV_LIMIT, got, start_lvl, stop_lvl, first_change, timed_out);
			if (timed_out)
				report_timeout($sformatf("start bit of echoed frame %0d", i));
			if (exp_q.size() == 0)
			begin
				$display("an echoed frame arrived at t=%0t with no byte outstanding", $time);
				abort_run();
			end
			exp = exp_q.pop_front();
			check_byte(got, exp, $sformatf("echoed frame %0d", i));
			check_line(start_lvl, 1'b0, "start bit centre");
			check_line(stop_lvl, 1'b1, "stop bit centre");
			// 8'h55 toggles at every bit, so its first change ends the start bit
			if (exp == 8'h55)
				check_cycles(baud_cnt_t'(first_change), baud_cnt_t'(CPB), "start bit of 8'h55");
		end
	endtask

	initial
	begin
		arst_n = 1'b0;
		seed   = 32'h68b7_6fdf;
		// the fixed bytes drive every data bit both low and high
		tx_bytes[0] = 8'h00;
		tx_bytes[1] = 8'hFF;
		tx_bytes[2] = 8'h55;
		tx_bytes[3] = 8'hAA;
		for (n = 0; n < 4; n++)
			tx_gaps[n] = 3;
		for (n = 4; n < NUM_FRAMES; n++)
		begin
			tx_bytes[n] = byte_t'($random(seed));
			tx_gaps[n]  = 2 + int'($unsigned($random(seed)) % 32'd4);
		end

		// reset for eight cycles, then a quiet input for fifty bit times
		for (cyc = 0; cyc < 8 + 50 * CPB; cyc++)
		begin
			@(negedge clk);
			check_line(uart_tx, 1'b1, "idle output line");
			if (cyc == 7)
				arst_n = 1'b1;
		end

		fork
			send_all();
			recv_all();
		join

		$display("Everything OK");
		$finish;
	end

endmodule

// File: logic/uart_echo_top.sv
module uart_echo_top #(
	parameter uart_pkg::baud_cnt_t CLOCKS_PER_BAUD = 24'd868
) (
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_uart_rx,
	output logic o_uart_tx
);
	import uart_pkg::*;

	//////////////////////////////////////////////////
	// echo path
	//////////////////////////////////////////////////

	// each decoded character goes straight back out, with no buffer
	// between the receiver and the transmitter
	// 868 clocks per bit gives 115200 baud from a 100 MHz clock

	rx_line_t rx_line;
	rx_byte_t rx_byte;

	// synchroniser and start bit detection
	uart_rx_front #(
		.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
	) rx_front0 (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_uart_rx (i_uart_rx),
		.o_line    (rx_line)
	);

	// frame decode, strobing one byte per character
	uart_rx #(
		.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
	) rx0 (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_line   (rx_line),
		.o_byte   (rx_byte)
	);

	// a strobe that lands while a frame is still going out is lost
	// the echo path has no handshake, so busy stays inside the transmitter
	uart_tx #(
		.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
	) tx0 (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_byte    (rx_byte),
		.o_uart_tx (o_uart_tx),
		.o_busy    ()
	);

endmodule

// File: logic/uart_pkg.sv
package uart_pkg;

	//////////////////////////////////////////////////
	// character framing
	//////////////////////////////////////////////////

	// every character is eight data bits with one stop bit and no parity
	localparam int DATA_BITS = 8;

	// counters are wide enough for very slow baud rates on a fast clock
	localparam int BAUD_W = 24;

	typedef logic [DATA_BITS-1:0] byte_t;

	// clock count inside one bit, or since the last edge on the line
	typedef logic [BAUD_W-1:0] baud_cnt_t;

	//////////////////////////////////////////////////
	// state encodings
	//////////////////////////////////////////////////

	// the receiver waits in idle and then walks through the data bits
	typedef enum logic [3:0] {
		RX_BIT0 = 4'h0,
		RX_BIT1 = 4'h1,
		RX_BIT2 = 4'h2,
		RX_BIT3 = 4'h3,
		RX_BIT4 = 4'h4,
		RX_BIT5 = 4'h5,
		RX_BIT6 = 4'h6,
		RX_BIT7 = 4'h7,
		RX_STOP = 4'h8,
		RX_IDLE = 4'hF
	} rx_state_e;

	// each transmitter state names the bit currently on the line
	typedef enum logic [3:0] {
		TX_START = 4'h0,
		TX_BIT0  = 4'h1,
		TX_BIT1  = 4'h2,
		TX_BIT2  = 4'h3,
		TX_BIT3  = 4'h4,
		TX_BIT4  = 4'h5,
		TX_BIT5  = 4'h6,
		TX_BIT6  = 4'h7,
		TX_BIT7  = 4'h8,
		TX_STOP  = 4'h9,
		TX_IDLE  = 4'hF
	} tx_state_e;

	//////////////////////////////////////////////////
	// links between blocks
	//////////////////////////////////////////////////

	// synchronised line level plus the start bit centre flag
	typedef struct packed {
		logic ck_bit;
		logic start_mid;
	} rx_line_t;

	// a received character with its one-cycle strobe
	typedef struct packed {
		logic  valid;
		byte_t data;
	} rx_byte_t;

endpackage

// File: logic/uart_rx.sv
module uart_rx #(
	parameter uart_pkg::baud_cnt_t CLOCKS_PER_BAUD = 24'd868
) (
	input  logic                i_clk,
	input  logic                i_arst_n,
	input  uart_pkg::rx_line_t  i_line,
	output uart_pkg::rx_byte_t  o_byte
);
	import uart_pkg::*;

	localparam baud_cnt_t BAUD_LAST = CLOCKS_PER_BAUD - baud_cnt_t'(1);

	rx_state_e state;
	baud_cnt_t baud_cnt;
	logic      zero_baud;
	byte_t     shift_reg;
	logic      valid_q;
	byte_t     data_q;

	//////////////////////////////////////////////////
	// frame state machine
	//////////////////////////////////////////////////

	// idle ignores the baud counter and only watches for a start centre
	// once running, each zero flag moves on to the next bit
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			state <= RX_IDLE;
		else if (state == RX_IDLE)
		begin
			if (i_line.start_mid)
				state <= RX_BIT0;
		end
		else if (zero_baud)
		begin
			if (state == RX_STOP)
				state <= RX_IDLE;
			else
				state <= rx_state_e'(state + 4'd1);
		end
	end

	//////////////////////////////////////////////////
	// bit timing
	//////////////////////////////////////////////////

	// idle keeps the counter loaded, so the first sample lands one
	// full bit after the start centre, in the middle of bit zero
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			baud_cnt <= BAUD_LAST;
		else if (zero_baud || (state == RX_IDLE))
			baud_cnt <= BAUD_LAST;
		else
			baud_cnt <= baud_cnt - baud_cnt_t'(1);
	end

	// the compare against zero is done a cycle ahead and registered
	// which keeps it out of the state decode paths
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			zero_baud <= 1'b0;
		else if (state == RX_IDLE)
			zero_baud <= 1'b0;
		else
			zero_baud <= (baud_cnt == baud_cnt_t'(1));
	end

	//////////////////////////////////////////////////
	// data capture
	//////////////////////////////////////////////////

	// bits arrive least significant first, so they enter at the top
	// and the stop sample shifts in too but is never copied out
	always_ff @(posedge i_clk)
	begin
		if (zero_baud)
			shift_reg <= {i_line.ck_bit, shift_reg[DATA_BITS-1:1]};
	end

	// one-cycle strobe at the stop sample
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			valid_q <= 1'b0;
		else
			valid_q <= zero_baud && (state == RX_STOP);
	end

	// the byte holds until the next character completes
	always_ff @(posedge i_clk)
	begin
		if (zero_baud && (state == RX_STOP))
			data_q <= shift_reg;
	end

	assign o_byte = '{valid: valid_q, data: data_q};

	// characters are at least ten bits apart so the strobe is single
	a_valid_single: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_byte.valid |=> !o_byte.valid
	);

	a_zero_flag: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		zero_baud |-> (baud_cnt == '0)
	);

endmodule

// File: logic/uart_rx_front.sv
module uart_rx_front #(
	parameter uart_pkg::baud_cnt_t CLOCKS_PER_BAUD = 24'd868
) (
	input  logic                i_clk,
	input  logic                i_arst_n,
	input  logic                i_uart_rx,
	output uart_pkg::rx_line_t  o_line
);
	import uart_pkg::*;

	// the start bit centre lies half a bit after its falling edge
	localparam baud_cnt_t HALF_BAUD = (CLOCKS_PER_BAUD >> 1) - baud_cnt_t'(1);

	// how far back the line must already have been low at a start centre
	localparam int LOW_TICKS = int'(HALF_BAUD) + 1;

	logic      q_uart;
	logic      qq_uart;
	logic      ck_uart;
	baud_cnt_t chg_cnt;
	logic      half_time;

	//////////////////////////////////////////////////
	// input synchroniser
	//////////////////////////////////////////////////

	// the line is asynchronous to i_clk so it passes three flops first
	// all stages come out of reset at the marking level
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			q_uart  <= 1'b1;
			qq_uart <= 1'b1;
			ck_uart <= 1'b1;
		end
		else
		begin
			q_uart  <= i_uart_rx;
			qq_uart <= q_uart;
			ck_uart <= qq_uart;
		end
	end

	//////////////////////////////////////////////////
	// time since the last line change
	//////////////////////////////////////////////////

	// an edge is seen between the last two stages one cycle before it
	// reaches ck_uart, so the count restarts as the new level arrives
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			chg_cnt <= '0;
		else if (qq_uart != ck_uart)
			chg_cnt <= '0;
		else
			chg_cnt <= chg_cnt + baud_cnt_t'(1);
	end

	// the line has been low for half a bit, so we sit near the centre
	// of a start bit and the receiver may begin counting whole bits
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			half_time <= 1'b0;
		else
			half_time <= !ck_uart && (chg_cnt >= HALF_BAUD);
	end

	assign o_line.ck_bit = ck_uart;

	// masked by the current level so a rising line clears it at once
	assign o_line.start_mid = half_time && !ck_uart;

	// a start centre needs the line low now and already half a bit earlier
	a_start_mid_low: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_line.start_mid |-> (!o_line.ck_bit && $past(!ck_uart, LOW_TICKS))
	);

endmodule

// File: logic/uart_tx.sv
module uart_tx #(
	parameter uart_pkg::baud_cnt_t CLOCKS_PER_BAUD = 24'd868
) (
	input  logic                i_clk,
	input  logic                i_arst_n,
	input  uart_pkg::rx_byte_t  i_byte,
	output logic                o_uart_tx,
	output logic                o_busy
);
	import uart_pkg::*;

	localparam baud_cnt_t BAUD_LAST = CLOCKS_PER_BAUD - baud_cnt_t'(1);

	tx_state_e state;
	baud_cnt_t baud_cnt;
	logic      zero_baud;
	byte_t     lcl_data;
	logic      accept;

	// a byte is taken only while idle, anything else is dropped
	assign accept = i_byte.valid && !o_busy;

	//////////////////////////////////////////////////
	// frame state machine and busy level
	//////////////////////////////////////////////////

	// busy is held high through every bit, including the whole stop bit
	// and falls only once idle has seen a zero flag
	// out of reset it is high for one cycle before idle clears it
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state  <= TX_IDLE;
			o_busy <= 1'b1;
		end
		else if (!zero_baud)
			o_busy <= 1'b1;
		else if (state == TX_IDLE)
		begin
			o_busy <= accept;
			if (accept)
				state <= TX_START;
		end
		else
		begin
			// a zero flag ends the current bit
			o_busy <= 1'b1;
			if (state == TX_STOP)
				state <= TX_IDLE;
			else
				state <= tx_state_e'(state + 4'd1);
		end
	end

	//////////////////////////////////////////////////
	// shift register and line driver
	//////////////////////////////////////////////////

	// working copy of the byte, shifted right as each bit goes out
	// ones fill in from the top, so the stop bit and the idle line follow
	// naturally once the data has gone
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			lcl_data <= '1;
		else if (accept)
			lcl_data <= i_byte.data;
		else if (zero_baud)
			lcl_data <= {1'b1, lcl_data[DATA_BITS-1:1]};
	end

	// the start bit goes out on the cycle after the byte is taken
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_uart_tx <= 1'b1;
		else if (accept)
			o_uart_tx <= 1'b0;
		else if (zero_baud)
			o_uart_tx <= lcl_data[0];
	end

	//////////////////////////////////////////////////
	// baud counter
	//////////////////////////////////////////////////

	// counts down from CLOCKS_PER_BAUD-1 for every bit on the line
	// in idle it rests at zero with the flag set, so a new byte starts
	// at once instead of waiting out some arbitrary bit period
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			baud_cnt  <= '0;
			zero_baud <= 1'b1;
		end
		else if (state == TX_IDLE)
		begin
			if (accept)
			begin
				baud_cnt  <= BAUD_LAST;
				zero_baud <= 1'b0;
			end
			else
			begin
				baud_cnt  <= '0;
				zero_baud <= 1'b1;
			end
		end
		else if (!zero_baud)
		begin
			baud_cnt  <= baud_cnt - baud_cnt_t'(1);
			zero_baud <= (baud_cnt == baud_cnt_t'(1));
		end
		else
		begin
			baud_cnt  <= BAUD_LAST;
			zero_baud <= 1'b0;
		end
	end

	// the line may only move once the bit counter has run down to zero
	a_line_steady: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		!$stable(o_uart_tx) |-> $past(baud_cnt == '0)
	);

	// a running bit period always reports busy upstream
	a_busy_cnt: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		(baud_cnt != '0) |-> o_busy
	);

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f vlog.f --top-module uart_echo_tb -o uart_echo_sim

status=0
./obj_dir/uart_echo_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation passed"

// File: vlog.f
logic/uart_pkg.sv
logic/uart_rx_front.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_echo_top.sv
bench/serial_line_model.sv
bench/uart_echo_tb.sv
